// ==== s16b_main.f ====
rtl/s16b_pkg.sv
rtl/s16b_bus_if.sv
rtl/s16b_mapper.sv
rtl/s16b_decode.sv
rtl/s16b_cabinet.sv
rtl/s16b_bus_return.sv
rtl/s16b_main.sv
sim/s16b_checker.sv
sim/s16b_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= s16b_tb
FILELIST   ?= s16b_main.f
FLAGS      ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
RUN_ARGS   ?= +verilator+error+limit+1000

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/s16b_tb.sv ====
`timescale 1ns/10ps

module s16b_tb;

    localparam int          TIMEOUT = 50;
    localparam logic [31:0] SEED    = 32'h3132cffc;

    logic        clk       = 1'b0;
    logic        rom_ok    = 1'b0;
    logic        ram_ok    = 1'b0;
    logic [15:0] rom_data  = 16'h0000;
    logic [15:0] ram_data  = 16'h0000;
    logic        vram_seen = 1'b0;
    logic        rst;
    logic [23:1] addr;
    logic [15:0] wdata;
    logic [1:0]  dsn;
    logic        rnw;
    logic        asn;
    logic [15:0] rdata;
    logic        dtackn;
    logic        rom_cs;
    logic [17:0] rom_addr;
    logic        ram_cs;
    logic        vram_cs;
    logic        char_cs;
    logic        pal_cs;
    logic        objram_cs;
    logic [15:0] char_dout;
    logic [15:0] pal_dout;
    logic [15:0] obj_dout;
    logic [5:0]  tile_bank;
    logic [7:0]  joystick1;
    logic [7:0]  joystick2;
    logic [1:0]  start_button;
    logic [1:0]  coin_input;
    logic        service;
    logic        dip_test;
    logic [7:0]  dipsw_a;
    logic [7:0]  dipsw_b;
    logic        flip;
    logic        video_en;

    logic [17:0] rom_addr_seen;
    string       test_name;
    int          test_errors;
    int          checks_failed;
    int          tests_run;
    int          tests_failed;

    always #20 clk = ~clk;

    s16b_main #(.ROM_AW(18)) dut (.*);

    // Memory model data from the word address folded to 16 bits
    function automatic logic [15:0] fold_addr(input logic [23:1] a);
        return a[16:1] ^ {9'd0, a[23:17]};
    endfunction

    always begin : rom_responder
        int unsigned delay;
        int          guard;
        @(posedge clk);
        #2;
        if (rom_cs) begin
            delay = $urandom_range(5, 0);
            repeat (delay) begin
                @(posedge clk);
                #2;
            end
            rom_data      = fold_addr({5'd0, rom_addr});
            rom_addr_seen = rom_addr;
            rom_ok        = 1'b1;
            guard = 0;
            while (rom_cs && guard < TIMEOUT) begin
                @(posedge clk);
                #2;
                guard++;
            end
            rom_ok = 1'b0;
        end
    end

    always begin : ram_responder
        int unsigned delay;
        int          guard;
        @(posedge clk);
        #2;
        if (ram_cs || vram_cs) begin
            vram_seen = vram_cs;
            delay = $urandom_range(5, 0);
            repeat (delay) begin
                @(posedge clk);
                #2;
            end
            ram_data = fold_addr(addr) ^ 16'ha5a5;
            ram_ok   = 1'b1;
            guard = 0;
            while ((ram_cs || vram_cs) && guard < TIMEOUT) begin
                @(posedge clk);
                #2;
                guard++;
            end
            ram_ok = 1'b0;
        end
    end

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        checks_failed += test_errors;
        if (test_errors == 0) begin
            $display("PASS %s", test_name);
        end else begin
            $display("FAIL %s, %0d errors", test_name, test_errors);
            tests_failed++;
        end
    endtask

    task automatic expect_equal(input string what, input logic [31:0] exp,
                                input logic [31:0] got);
        assert (got === exp) else begin
            $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, got);
            test_errors++;
        end
    endtask

    // One 68000 style cycle entered and left 2 ns after a rising edge
    task automatic bus_cycle(input logic [23:0] ba, input logic write,
                             input logic [15:0] d, output logic [15:0] q);
        int n;
        addr  = ba[23:1];
        wdata = d;
        rnw   = !write;
        dsn   = 2'b00;
        asn   = 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            #2;
            n++;
        end while (dtackn && n < TIMEOUT);
        if (dtackn) begin
            $display("%s: no DTACK within %0d cycles at address %h", test_name, TIMEOUT, ba);
            test_errors++;
        end
        q   = rdata;
        asn = 1'b1;
        rnw = 1'b1;
        dsn = 2'b11;
        n = 0;
        do begin
            @(posedge clk);
            #2;
            n++;
        end while (!dtackn && n < TIMEOUT);
        if (!dtackn) begin
            $display("%s: DTACK stayed low after the address strobe rose", test_name);
            test_errors++;
        end
    endtask

    task automatic bus_read(input logic [23:0] ba, output logic [15:0] q);
        bus_cycle(ba, 1'b0, 16'h0000, q);
    endtask

    task automatic bus_write(input logic [23:0] ba, input logic [15:0] d);
        logic [15:0] ignored;
        bus_cycle(ba, 1'b1, d, ignored);
    endtask

    // Even register holds the base and the odd register the enable and size
    task automatic map_region(input int r, input logic [7:0] base, input logic [2:0] size);
        logic [23:0] reg_addr;
        reg_addr = 24'hf00000 | 24'(r << 2);
        bus_write(reg_addr, {8'h00, base});
        bus_write(reg_addr | 24'h000002, {12'h000, 1'b1, size});
    endtask

    initial begin : main
        logic [15:0] q;
        logic [15:0] prev;
        logic [23:0] ba;
        logic [2:0]  lo;
        logic [2:0]  hi;
        int          assert_fails;
        void'($urandom(SEED));
        rst           = 1'b1;
        addr          = '0;
        wdata         = 16'h0000;
        dsn           = 2'b11;
        rnw           = 1'b1;
        asn           = 1'b1;
        char_dout     = 16'($urandom);
        pal_dout      = 16'($urandom);
        obj_dout      = 16'($urandom);
        joystick1     = 8'hff;
        joystick2     = 8'hff;
        start_button  = 2'b11;
        coin_input    = 2'b11;
        service       = 1'b1;
        dip_test      = 1'b1;
        dipsw_a       = 8'hff;
        dipsw_b       = 8'hff;
        rom_addr_seen = '1;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        start_test("reset_state");
        expect_equal("rdata", 16'hffff, rdata);
        expect_equal("dtackn", 1, dtackn);
        expect_equal("selects", 0, {rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs});
        expect_equal("tile_bank", 0, tile_bank);
        expect_equal("flip and video_en", 0, {flip, video_en});
        bus_read(24'h000000, q);
        expect_equal("rom_addr", 0, rom_addr_seen);
        expect_equal("boot read", fold_addr(23'd0), q);
        end_test();

        start_test("mapper");
        map_region(s16b_pkg::REG_RAM, 8'h20, 3'd0);
        map_region(s16b_pkg::REG_ROM1, 8'h40, 3'd1);
        bus_read(24'hf0000c, q);
        expect_equal("region 3 base", 16'hff20, q);
        ba = {8'h20, 15'($urandom), 1'b0};
        bus_read(ba, q);
        expect_equal("ram data", fold_addr(ba[23:1]) ^ 16'ha5a5, q);
        ba = {8'h41, 15'($urandom), 1'b0};
        bus_read(ba, q);
        expect_equal("rom_addr", {2'd1, ba[16:1]}, rom_addr_seen);
        expect_equal("rom data", fold_addr({5'd0, 2'd1, ba[16:1]}), q);
        end_test();

        start_test("back_pressure");
        map_region(s16b_pkg::REG_VRAM, 8'h30, 3'd1);
        for (int i = 0; i < 8; i++) begin
            ba = {(i % 2 == 0) ? 8'h20 : 8'h30, 15'($urandom), 1'b0};
            bus_read(ba, q);
            expect_equal("ram data", fold_addr(ba[23:1]) ^ 16'ha5a5, q);
            expect_equal("vram_cs", i % 2, vram_seen);
        end
        // Upper half of the video region is the char RAM
        bus_read({8'h31, 15'($urandom), 1'b0}, q);
        expect_equal("char data", char_dout, q);
        end_test();

        start_test("video_targets");
        map_region(s16b_pkg::REG_ORAM, 8'h80, 3'd0);
        map_region(s16b_pkg::REG_PAL, 8'h90, 3'd0);
        bus_read({8'h80, 15'($urandom), 1'b0}, q);
        expect_equal("object data", obj_dout, q);
        bus_read({8'h90, 15'($urandom), 1'b0}, q);
        expect_equal("palette data", pal_dout, q);
        end_test();

        start_test("tile_bank");
        map_region(s16b_pkg::REG_ROM2, 8'h50, 3'd0);
        lo = 3'($urandom_range(6, 1));
        hi = ~lo;
        bus_write(24'h500000, {13'd0, lo});
        bus_write(24'h500002, {13'd0, hi});
        expect_equal("tile_bank", {hi, lo}, tile_bank);
        end_test();

        start_test("cabinet");
        map_region(s16b_pkg::REG_IO, 8'h60, 3'd0);
        joystick1    = 8'($urandom);
        joystick2    = 8'($urandom);
        start_button = 2'($urandom);
        coin_input   = 2'($urandom);
        service      = 1'($urandom);
        dip_test     = 1'($urandom);
        dipsw_a      = 8'($urandom);
        dipsw_b      = 8'($urandom);
        bus_read(24'h600000, q);
        expect_equal("system",
                     {8'hff, 2'b11, start_button, dip_test, service, coin_input}, q);
        bus_read(24'h601000, q);
        expect_equal("player 1", {8'hff, joystick1}, q);
        bus_read(24'h602000, q);
        expect_equal("player 2", {8'hff, joystick2}, q);
        bus_read(24'h603000, q);
        expect_equal("dip a", {8'hff, dipsw_a}, q);
        bus_read(24'h603002, q);
        expect_equal("dip b", {8'hff, dipsw_b}, q);
        bus_write(24'h600000, 16'h0040);
        expect_equal("flip only", 2'b10, {flip, video_en});
        bus_write(24'h600000, 16'h0060);
        expect_equal("flip and video_en", 2'b11, {flip, video_en});
        end_test();

        start_test("unmapped");
        bus_read({8'h20, 15'($urandom), 1'b0}, prev);
        bus_read(24'h700000, q);
        expect_equal("held rdata", prev, q);
        end_test();

        assert_fails = dut.chk.fail_count;
        $display("Tests run %0d, failed %0d, check errors %0d, assertion errors %0d",
                 tests_run, tests_failed, checks_failed, assert_fails);
        if (checks_failed == 0 && assert_fails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== sim/s16b_checker.sv ====
`timescale 1ns/10ps

module s16b_checker (
    input logic clk,
    input logic rst,
    input logic asn,
    input logic dtackn,
    input logic rom_cs,
    input logic rom_ok,
    input logic ram_cs,
    input logic vram_cs,
    input logic ram_ok,
    input logic char_cs,
    input logic pal_cs,
    input logic objram_cs,
    input logic io_cs,
    input logic map_cs
);

    int         fail_count = 0;
    logic [7:0] selects;

    assign selects = {rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs, io_cs, map_cs};

    one_select: assert property (@(posedge clk) disable iff (rst) $onehot0(selects))
        else begin
            $error("more than one chip select active: %b", selects);
            fail_count++;
        end

    // DTACK may lag the rising address strobe by one cycle only
    dtack_release: assert property (@(posedge clk) disable iff (rst)
        asn && $past(asn) |-> dtackn)
        else begin
            $error("dtackn low while the address strobe is high");
            fail_count++;
        end

    dtack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        $fell(dtackn) |-> !$past(asn))
        else begin
            $error("dtackn fell outside a bus cycle");
            fail_count++;
        end

    rom_hold: assert property (@(posedge clk) disable iff (rst)
        rom_cs && dtackn |=> rom_cs)
        else begin
            $error("rom_cs dropped before DTACK");
            fail_count++;
        end

    ram_hold: assert property (@(posedge clk) disable iff (rst)
        (ram_cs || vram_cs) && dtackn |=> (ram_cs || vram_cs))
        else begin
            $error("ram_cs or vram_cs dropped before DTACK");
            fail_count++;
        end

    // Slow memories gate DTACK through their ok
    rom_ok_first: assert property (@(posedge clk) disable iff (rst)
        $fell(dtackn) && $past(rom_cs) |-> $past(rom_ok))
        else begin
            $error("ROM DTACK without rom_ok");
            fail_count++;
        end

    ram_ok_first: assert property (@(posedge clk) disable iff (rst)
        $fell(dtackn) && $past(ram_cs || vram_cs) |-> $past(ram_ok))
        else begin
            $error("RAM DTACK without ram_ok");
            fail_count++;
        end

    reset_clear: assert property (@(posedge clk) $fell(rst) |-> selects == 8'h00)
        else begin
            $error("chip selects active right after reset");
            fail_count++;
        end

endmodule

bind s16b_main s16b_checker chk (
    .clk       (clk),
    .rst       (rst),
    .asn       (asn),
    .dtackn    (dtackn),
    .rom_cs    (rom_cs),
    .rom_ok    (rom_ok),
    .ram_cs    (ram_cs),
    .vram_cs   (vram_cs),
    .ram_ok    (ram_ok),
    .char_cs   (char_cs),
    .pal_cs    (pal_cs),
    .objram_cs (objram_cs),
    .io_cs     (io_cs),
    .map_cs    (map_cs)
);

// ==== rtl/s16b_main.sv ====
`timescale 1ns/10ps

module s16b_main #(
    parameter int ROM_AW = 18
) (
    input  logic                          clk,
    input  logic                          rst,
    // 68000 style bus
    input  logic [s16b_pkg::ADDR_W:1]     addr,
    input  logic [s16b_pkg::DATA_W-1:0]   wdata,
    input  logic [1:0]                    dsn,
    input  logic                          rnw,
    input  logic                          asn,
    output logic [s16b_pkg::DATA_W-1:0]   rdata,
    output logic                          dtackn,
    // Program ROM
    output logic                          rom_cs,
    output logic [ROM_AW-1:0]             rom_addr,
    input  logic [15:0]                   rom_data,
    input  logic                          rom_ok,
    // Work RAM and video RAM
    output logic                          ram_cs,
    output logic                          vram_cs,
    input  logic [15:0]                   ram_data,
    input  logic                          ram_ok,
    // Video memories
    output logic                          char_cs,
    output logic                          pal_cs,
    output logic                          objram_cs,
    input  logic [15:0]                   char_dout,
    input  logic [15:0]                   pal_dout,
    input  logic [15:0]                   obj_dout,
    output logic [5:0]                    tile_bank,
    // Cabinet
    input  logic [7:0]                    joystick1,
    input  logic [7:0]                    joystick2,
    input  logic [1:0]                    start_button,
    input  logic [1:0]                    coin_input,
    input  logic                          service,
    input  logic                          dip_test,
    input  logic [7:0]                    dipsw_a,
    input  logic [7:0]                    dipsw_b,
    output logic                          flip,
    output logic                          video_en
);

    logic       io_cs;
    logic       map_cs;
    logic [7:0] cab_dout;
    logic [7:0] map_dout;

    s16b_bus_if bus();

    assign bus.addr  = addr;
    assign bus.wdata = wdata;
    assign bus.dsn   = dsn;
    assign bus.rnw   = rnw;
    assign bus.asn   = asn;

    s16b_mapper u_mapper (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus.mapper),
        .map_cs   (map_cs),
        .map_dout (map_dout)
    );

    s16b_decode #(
        .ROM_AW (ROM_AW)
    ) u_decode (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus.decode),
        .rom_cs    (rom_cs),
        .rom_addr  (rom_addr),
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .char_cs   (char_cs),
        .pal_cs    (pal_cs),
        .objram_cs (objram_cs),
        .io_cs     (io_cs),
        .map_cs    (map_cs),
        .tile_bank (tile_bank)
    );

    s16b_cabinet u_cabinet (
        .clk          (clk),
        .rst          (rst),
        .bus          (bus.cabinet),
        .io_cs        (io_cs),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dip_test     (dip_test),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .cab_dout     (cab_dout),
        .flip         (flip),
        .video_en     (video_en)
    );

    s16b_bus_return u_bus_return (
        .clk       (clk),
        .rst       (rst),
        .asn       (asn),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .char_cs   (char_cs),
        .pal_cs    (pal_cs),
        .objram_cs (objram_cs),
        .io_cs     (io_cs),
        .map_cs    (map_cs),
        .rom_ok    (rom_ok),
        .ram_ok    (ram_ok),
        .rom_data  (rom_data),
        .ram_data  (ram_data),
        .char_dout (char_dout),
        .pal_dout  (pal_dout),
        .obj_dout  (obj_dout),
        .cab_dout  (cab_dout),
        .map_dout  (map_dout),
        .rdata     (rdata),
        .dtackn    (dtackn)
    );

endmodule

// ==== rtl/s16b_bus_return.sv ====
`timescale 1ns/10ps

module s16b_bus_return (
    input  logic        clk,
    input  logic        rst,
    input  logic        asn,
    input  logic        rom_cs,
    input  logic        ram_cs,
    input  logic        vram_cs,
    input  logic        char_cs,
    input  logic        pal_cs,
    input  logic        objram_cs,
    input  logic        io_cs,
    input  logic        map_cs,
    input  logic        rom_ok,
    input  logic        ram_ok,
    input  logic [15:0] rom_data,
    input  logic [15:0] ram_data,
    input  logic [15:0] char_dout,
    input  logic [15:0] pal_dout,
    input  logic [15:0] obj_dout,
    input  logic [7:0]  cab_dout,
    input  logic [7:0]  map_dout,
    output logic [15:0] rdata,
    output logic        dtackn
);

    logic ext_ok;
    logic int_cs;
    logic any_cs;
    logic asn_seen;

    // Slow memories are ready only while their ok is high
    assign ext_ok = (rom_cs & rom_ok) | ((ram_cs | vram_cs) & ram_ok);
    assign int_cs = char_cs | pal_cs | objram_cs | io_cs | map_cs;
    assign any_cs = rom_cs | ram_cs | vram_cs | int_cs;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdata <= 16'hffff;
        end else if ((ram_cs | vram_cs) & ram_ok) begin
            rdata <= ram_data;
        end else if (rom_cs & rom_ok) begin
            rdata <= rom_data;
        end else if (char_cs) begin
            rdata <= char_dout;
        end else if (pal_cs) begin
            rdata <= pal_dout;
        end else if (objram_cs) begin
            rdata <= obj_dout;
        end else if (io_cs) begin
            rdata <= {8'hff, cab_dout};
        end else if (map_cs) begin
            rdata <= {8'hff, map_dout};
        end
    end

    // Second low cycle of asn with no select ends an unmapped access
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            asn_seen <= 1'b0;
            dtackn   <= 1'b1;
        end else begin
            asn_seen <= !asn;
            if (asn) begin
                dtackn <= 1'b1;
            end else if (ext_ok || int_cs || (asn_seen && !any_cs)) begin
                dtackn <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/s16b_cabinet.sv ====
`timescale 1ns/10ps

module s16b_cabinet (
    input  logic        clk,
    input  logic        rst,
    s16b_bus_if.cabinet bus,
    input  logic        io_cs,
    input  logic [7:0]  joystick1,
    input  logic [7:0]  joystick2,
    input  logic [1:0]  start_button,
    input  logic [1:0]  coin_input,
    input  logic        service,
    input  logic        dip_test,
    input  logic [7:0]  dipsw_a,
    input  logic [7:0]  dipsw_b,
    output logic [7:0]  cab_dout,
    output logic        flip,
    output logic        video_en
);

    s16b_pkg::cab_offset_t offset;
    logic [7:0]            sys_inputs;
    logic                  sys_we;

    assign offset = s16b_pkg::cab_offset_t'(bus.addr[13:12]);

    // Cabinet inputs arrive active low and pass straight through
    assign sys_inputs = {2'b11, start_button, dip_test, service, coin_input};

    always_comb begin
        case (offset)
            s16b_pkg::CAB_SYS: cab_dout = sys_inputs;
            s16b_pkg::CAB_P1:  cab_dout = joystick1;
            s16b_pkg::CAB_P2:  cab_dout = joystick2;
            s16b_pkg::CAB_DIP: cab_dout = bus.addr[1] ? dipsw_b : dipsw_a;
            default:           cab_dout = 8'hff;
        endcase
    end

    // Control latch on lower byte writes at the system offset
    assign sys_we = io_cs && !bus.rnw && !bus.dsn[0] && offset == s16b_pkg::CAB_SYS;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flip     <= 1'b0;
            video_en <= 1'b0;
        end else if (sys_we) begin
            video_en <= bus.wdata[5];
            flip     <= bus.wdata[6];
        end
    end

endmodule

// ==== rtl/s16b_decode.sv ====
`timescale 1ns/10ps

module s16b_decode #(
    parameter int ROM_AW = 18
) (
    input  logic              clk,
    input  logic              rst,
    s16b_bus_if.decode        bus,
    output logic              rom_cs,
    output logic [ROM_AW-1:0] rom_addr,
    output logic              ram_cs,
    output logic              vram_cs,
    output logic              char_cs,
    output logic              pal_cs,
    output logic              objram_cs,
    output logic              io_cs,
    output logic              map_cs,
    output logic [5:0]        tile_bank
);

    localparam int AW = s16b_pkg::ADDR_W;

    logic       map_sel;
    logic [1:0] rom_enc;
    logic       tbank_we;

    // Mapper window takes priority over every region
    assign map_sel = bus.addr[AW:20] == s16b_pkg::MAP_SEL;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            pal_cs    <= 1'b0;
            objram_cs <= 1'b0;
            io_cs     <= 1'b0;
            map_cs    <= 1'b0;
        end else if (!bus.asn) begin
            map_cs    <= map_sel;
            rom_cs    <= !map_sel && bus.rnw &&
                         |bus.active[s16b_pkg::REG_ROM2:s16b_pkg::REG_ROM0];
            ram_cs    <= !map_sel && bus.active[s16b_pkg::REG_RAM];
            // Video region splits on address bit 16
            char_cs   <= !map_sel && bus.active[s16b_pkg::REG_VRAM] && bus.addr[16];
            vram_cs   <= !map_sel && bus.active[s16b_pkg::REG_VRAM] && !bus.addr[16];
            pal_cs    <= !map_sel && bus.active[s16b_pkg::REG_PAL];
            objram_cs <= !map_sel && bus.active[s16b_pkg::REG_ORAM];
            io_cs     <= !map_sel && bus.active[s16b_pkg::REG_IO];
        end else begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            pal_cs    <= 1'b0;
            objram_cs <= 1'b0;
            io_cs     <= 1'b0;
            map_cs    <= 1'b0;
        end
    end

    // Encoding of the active ROM region
    always_comb begin
        case (bus.active[s16b_pkg::REG_ROM2:s16b_pkg::REG_ROM0])
            3'b010:  rom_enc = 2'd1;
            3'b100:  rom_enc = 2'd2;
            default: rom_enc = 2'd0;
        endcase
    end

    assign rom_addr = {rom_enc, bus.addr[ROM_AW-2:1]};

    // Tile bank sits behind ROM region 2 on writes
    assign tbank_we = !bus.asn && !map_sel && !bus.rnw && !bus.dsn[0] &&
                      bus.active[s16b_pkg::REG_ROM2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tile_bank <= 6'd0;
        end else if (tbank_we) begin
            if (bus.addr[1]) begin
                tile_bank[5:3] <= bus.wdata[2:0];
            end else begin
                tile_bank[2:0] <= bus.wdata[2:0];
            end
        end
    end

endmodule

// ==== rtl/s16b_mapper.sv ====
`timescale 1ns/10ps

module s16b_mapper (
    input  logic        clk,
    input  logic        rst,
    s16b_bus_if.mapper  bus,
    input  logic        map_cs,
    output logic [7:0]  map_dout
);

    localparam int NREG  = s16b_pkg::NUM_REGIONS;
    localparam int IDX_W = $clog2(NREG);
    localparam int AW    = s16b_pkg::ADDR_W;

    s16b_pkg::region_t regs [NREG];

    logic [IDX_W-1:0] reg_idx;
    logic             map_we;
    logic [NREG-1:0]  match;

    // Bit 1 picks base or enable/size and the bits above pick the region
    assign reg_idx = bus.addr[IDX_W+1:2];

    // Lower byte write only
    assign map_we = map_cs && !bus.rnw && !bus.dsn[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < NREG; r++) begin
                if (r == s16b_pkg::REG_ROM0) begin
                    regs[r] <= s16b_pkg::BOOT_REGION;
                end else begin
                    regs[r] <= '0;
                end
            end
        end else if (map_we) begin
            if (bus.addr[1]) begin
                regs[reg_idx].en   <= bus.wdata[s16b_pkg::MAP_EN_BIT];
                regs[reg_idx].size <= bus.wdata[2:0];
            end else begin
                regs[reg_idx].base <= bus.wdata[7:0];
            end
        end
    end

    // Region compare on address bits 23:16 with the low size bits of the base ignored
    always_comb begin
        for (int r = 0; r < NREG; r++) begin
            match[r] = regs[r].en &&
                (((bus.addr[AW:16] ^ regs[r].base) & (8'hff << regs[r].size)) == 8'h00);
        end
    end

    // Lowest matching region wins
    assign bus.active = match & (~match + 1'b1);

    // Register read back
    always_comb begin
        map_dout = 8'h00;
        if (bus.addr[1]) begin
            map_dout[s16b_pkg::MAP_EN_BIT] = regs[reg_idx].en;
            map_dout[2:0]                  = regs[reg_idx].size;
        end else begin
            map_dout = regs[reg_idx].base;
        end
    end

endmodule

// ==== rtl/s16b_bus_if.sv ====
`timescale 1ns/10ps

interface s16b_bus_if;

    logic [s16b_pkg::ADDR_W:1]        addr;
    logic [s16b_pkg::DATA_W-1:0]      wdata;
    // Upper and lower data strobes, active low
    logic [1:0]                       dsn;
    logic                             rnw;
    logic                             asn;
    // One-hot region activity from the mapper
    logic [s16b_pkg::NUM_REGIONS-1:0] active;

    modport mapper (
        input  addr, wdata, dsn, rnw,
        output active
    );

    modport decode (
        input addr, wdata, dsn, rnw, asn, active
    );

    modport cabinet (
        input addr, wdata, dsn, rnw
    );

endinterface

// ==== rtl/s16b_pkg.sv ====
package s16b_pkg;

    // Bus widths with the address as a word address over bits 23:1
    localparam int ADDR_W = 23;
    localparam int DATA_W = 16;

    // Mapper regions
    localparam int NUM_REGIONS = 8;

    localparam int REG_ROM0 = 0;
    localparam int REG_ROM1 = 1;
    localparam int REG_ROM2 = 2;
    localparam int REG_RAM  = 3;
    localparam int REG_ORAM = 4;
    localparam int REG_VRAM = 5;
    localparam int REG_PAL  = 6;
    localparam int REG_IO   = 7;

    // Upper address nibble of the mapper registers
    localparam logic [3:0] MAP_SEL = 4'hf;

    // Enable bit of the odd mapper register sits above the 3-bit size
    localparam int MAP_EN_BIT = 3;

    typedef struct packed {
        logic       en;
        logic [7:0] base;
        logic [2:0] size;
    } region_t;

    // Boot map with 512 kB of ROM at address 0
    localparam region_t BOOT_REGION = '{en: 1'b1, base: 8'h00, size: 3'd3};

    typedef enum logic [1:0] {
        CAB_SYS = 2'd0,
        CAB_P1  = 2'd1,
        CAB_P2  = 2'd2,
        CAB_DIP = 2'd3
    } cab_offset_t;

endpackage
